// File: rtl/trace_pkg.sv
// every frame is a fixed 6 bytes, FIFO depth and bank count must stay powers of two
package trace_pkg;

  // CSR side
  localparam int CsrAddrWidth = 12;
  localparam logic [CsrAddrWidth-1:0] TraceCsrAddr = 12'h7c0;

  // free-running cycle counter, only the captured value is traced
  localparam int TimerWidth = 8;

  // record kind byte
  localparam logic [7:0] KindIrqEntry = 8'h01;
  localparam logic [7:0] KindTailChain = 8'h02;
  localparam logic [7:0] KindMark = 8'h03;

  // kind, id, prio, timer
  localparam int RecordBytes = 4;
  // COBS code byte plus zero delimiter on top of the record
  localparam int FrameBytes = RecordBytes + 2;

  // byte FIFO, interleaved over banks
  localparam int FifoDepth = 32;
  localparam int FifoBanks = 8;
  localparam int FifoBankDepth = FifoDepth / FifoBanks;
  localparam int BankSelWidth = $clog2(FifoBanks);
  localparam int FifoPtrWidth = $clog2(FifoDepth);
  localparam int FifoCountWidth = 6;

  // 8N1 serial line
  localparam int UartBitCycles = 4;
  localparam int UartCntWidth = $clog2(UartBitCycles);

endpackage

// File: rtl/trace_encoder.sv
// one event per cycle at most, interrupt wins over a mark; rs1 bits 31:16 are never traced
`timescale 1ns/10ps

module trace_encoder (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic                                irq_valid_i,
  input  logic [7:0]                          irq_id_i,
  input  logic [7:0]                          irq_prio_i,
  input  logic                                tail_chain_i,
  input  logic                                csr_enable_i,
  input  logic [trace_pkg::CsrAddrWidth-1:0]  csr_addr_i,
  input  logic [31:0]                         rs1_data_i,
  output logic                                frame_valid_o,
  output logic [8*trace_pkg::FrameBytes-1:0]  frame_data_o
);
  import trace_pkg::*;

  logic [TimerWidth-1:0] timer;
  logic                  mark_hit;
  logic                  event_valid;
  logic [7:0]            record [RecordBytes];
  logic [7:0]            frame [FrameBytes];
  logic [2:0]            next_zero;

  // trace-mark register decode
  assign mark_hit = csr_enable_i && (csr_addr_i == TraceCsrAddr);
  assign event_valid = irq_valid_i || mark_hit;

  // record fields
  always_comb begin
    if (irq_valid_i) begin
      record[0] = tail_chain_i ? KindTailChain : KindIrqEntry;
      record[1] = irq_id_i;
      record[2] = irq_prio_i;
    end else begin
      record[0] = KindMark;
      record[1] = rs1_data_i[15:8];
      record[2] = rs1_data_i[7:0];
    end
    record[3] = timer;
  end

  // COBS, walk backwards so each zero learns the distance to the next one
  // the delimiter position counts as the final zero
  always_comb begin
    next_zero = 3'(FrameBytes - 1);
    for (int i = RecordBytes; i >= 1; i--) begin
      if (record[i-1] == 8'h00) begin
        frame[i] = 8'(next_zero - 3'(i));
        next_zero = 3'(i);
      end else begin
        frame[i] = record[i-1];
      end
    end
    frame[0] = 8'(next_zero);
    frame[FrameBytes-1] = 8'h00;
  end

  // timer is 0 in the first cycle out of reset
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      timer <= '0;
      frame_valid_o <= 1'b0;
    end else begin
      timer <= timer + 1'b1;
      frame_valid_o <= event_valid;
    end
  end

  // first frame byte in the low bits
  always_ff @(posedge clk_i) begin
    if (event_valid) begin
      for (int k = 0; k < FrameBytes; k++) begin
        frame_data_o[8*k +: 8] <= frame[k];
      end
    end
  end

  // both sources at once means the mark is lost
  ap_single_source: assert property (
    @(posedge clk_i) disable iff (reset_i)
    !(irq_valid_i && mark_hit)
  ) else $error("interrupt and trace mark in the same cycle, mark dropped");

endmodule

// File: rtl/trace_fifo.sv
// takes whole 6-byte frames only; a frame that does not fit is dropped, never split
`timescale 1ns/10ps

module trace_fifo (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic                                frame_valid_i,
  input  logic [8*trace_pkg::FrameBytes-1:0]  frame_data_i,
  input  logic                                byte_ack_i,
  output logic                                byte_avail_o,
  output logic [7:0]                          byte_data_o,
  output logic                                drop_o
);
  import trace_pkg::*;

  logic [7:0]                  mem [FifoBanks][FifoBankDepth];
  logic [FifoPtrWidth-1:0]     wr_ptr;
  logic [FifoPtrWidth-1:0]     rd_ptr;
  logic [FifoPtrWidth-1:0]     wr_addr [FrameBytes];
  logic [FifoCountWidth-1:0]   count;
  logic                        accept;
  logic                        pop;

  // free space test uses the count before any pop this cycle
  assign accept = frame_valid_i && (count <= FifoCountWidth'(FifoDepth - FrameBytes));
  assign drop_o = frame_valid_i && !accept;

  assign byte_avail_o = (count != '0);
  assign pop = byte_ack_i && byte_avail_o;

  // low pointer bits pick the bank, high bits the row
  assign byte_data_o = mem[rd_ptr[BankSelWidth-1:0]][rd_ptr[FifoPtrWidth-1:BankSelWidth]];

  // consecutive addresses land in distinct banks
  always_comb begin
    for (int k = 0; k < FrameBytes; k++) begin
      wr_addr[k] = wr_ptr + FifoPtrWidth'(k);
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      for (int k = 0; k < FrameBytes; k++) begin
        mem[wr_addr[k][BankSelWidth-1:0]][wr_addr[k][FifoPtrWidth-1:BankSelWidth]] <=
          frame_data_i[8*k +: 8];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (accept) begin
        wr_ptr <= wr_ptr + FifoPtrWidth'(FrameBytes);
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + (accept ? FifoCountWidth'(FrameBytes) : '0) - FifoCountWidth'(pop);
    end
  end

  ap_count_bound: assert property (
    @(posedge clk_i) disable iff (reset_i)
    count <= FifoCountWidth'(FifoDepth)
  ) else $error("fifo fill count above depth");

  // transmitter must only take a byte that is there
  ap_no_ack_empty: assert property (
    @(posedge clk_i) disable iff (reset_i)
    byte_ack_i |-> byte_avail_o
  ) else $error("byte acknowledged while fifo empty");

endmodule

// File: rtl/uart_tx.sv
// 8N1, fixed bit period from the package; back-to-back bytes run with no idle gap
`timescale 1ns/10ps

module uart_tx (
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       byte_avail_i,
  input  logic [7:0] byte_data_i,
  output logic       byte_ack_o,
  output logic       tx_o
);
  import trace_pkg::*;

  typedef enum logic {
    st_idle,
    st_shift
  } state_t;

  state_t                  state;
  logic [UartCntWidth-1:0] bit_cnt;
  logic [3:0]              bit_idx;
  logic [8:0]              shreg;
  logic                    tx_q;
  logic                    bit_end;
  logic                    last_cycle;

  assign bit_end = (bit_cnt == UartCntWidth'(UartBitCycles - 1));
  // bit 0 start, 1..8 data, 9 stop
  assign last_cycle = (state == st_shift) && bit_end && (bit_idx == 4'd9);
  // take a byte when idle or as the stop bit ends
  assign byte_ack_o = byte_avail_i && ((state == st_idle) || last_cycle);
  assign tx_o = tx_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state <= st_idle;
      bit_cnt <= '0;
      bit_idx <= '0;
      tx_q <= 1'b1;
    end else if (byte_ack_o) begin
      state <= st_shift;
      bit_cnt <= '0;
      bit_idx <= '0;
      tx_q <= 1'b0;
    end else if (last_cycle) begin
      state <= st_idle;
      tx_q <= 1'b1;
    end else if (state == st_shift) begin
      if (bit_end) begin
        bit_cnt <= '0;
        bit_idx <= bit_idx + 1'b1;
        tx_q <= shreg[0];
      end else begin
        bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

  // stop bit sits above the data and shifts in behind it
  always_ff @(posedge clk_i) begin
    if (byte_ack_o) begin
      shreg <= {1'b1, byte_data_i};
    end else if ((state == st_shift) && bit_end) begin
      shreg <= {1'b1, shreg[8:1]};
    end
  end

  ap_idle_high: assert property (
    @(posedge clk_i) disable iff (reset_i)
    (state == st_idle) |-> tx_o
  ) else $error("tx line low while transmitter idle");

endmodule

// File: rtl/trace_top.sv
// trace path only, interrupt controller and CSR write come in from outside the core
`timescale 1ns/10ps

module trace_top (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic                                irq_valid_i,
  input  logic [7:0]                          irq_id_i,
  input  logic [7:0]                          irq_prio_i,
  input  logic                                tail_chain_i,
  input  logic                                csr_enable_i,
  input  logic [trace_pkg::CsrAddrWidth-1:0]  csr_addr_i,
  input  logic [31:0]                         rs1_data_i,
  output logic                                tx_o,
  output logic                                drop_o
);
  import trace_pkg::*;

  logic                    frame_valid;
  logic [8*FrameBytes-1:0] frame_data;
  logic                    byte_avail;
  logic [7:0]              byte_data;
  logic                    byte_ack;

  trace_encoder enc (
    .clk_i,
    .reset_i,
    .irq_valid_i,
    .irq_id_i,
    .irq_prio_i,
    .tail_chain_i,
    .csr_enable_i,
    .csr_addr_i,
    .rs1_data_i,
    .frame_valid_o(frame_valid),
    .frame_data_o (frame_data)
  );

  trace_fifo fifo_i (
    .clk_i,
    .reset_i,
    .frame_valid_i(frame_valid),
    .frame_data_i (frame_data),
    .byte_ack_i   (byte_ack),
    .byte_avail_o (byte_avail),
    .byte_data_o  (byte_data),
    .drop_o
  );

  uart_tx i_uart (
    .clk_i,
    .reset_i,
    .byte_avail_i(byte_avail),
    .byte_data_i (byte_data),
    .byte_ack_o  (byte_ack),
    .tx_o
  );

endmodule

// File: test/trace_checker.sv
// samples tx_o mid-bit on the clock grid and needs a bit period of at least 4 cycles
`timescale 1ns/10ps

module trace_checker (
  input logic clk_i,
  input logic reset_i,
  input logic tx_i,
  input logic drop_i
);
  import trace_pkg::*;

  localparam int HalfBit = UartBitCycles / 2;

  logic [7:0] exp_q [$];
  int         exp_test_q [$];
  int         drop_expected;
  int         drop_seen;
  int         byte_idx;
  int         test_errors;
  int         error_count;
  int         tests_run;
  int         tests_failed;
  logic       rx_busy;
  int         tick;
  int         bit_num;
  logic [7:0] rx_byte;

  task automatic report_error(input string msg);
    $display("%s", msg);
    error_count++;
    test_errors++;
  endtask

  task automatic expect_byte(input int tnum, input logic [7:0] value);
    exp_q.push_back(value);
    exp_test_q.push_back(tnum);
  endtask

  task automatic expect_drops(input int count);
    drop_expected = count;
  endtask

  function automatic int pending();
    return exp_q.size();
  endfunction

  task automatic check_byte(input logic [7:0] got);
    logic [7:0] want;
    int         tnum;
    if (exp_q.size() == 0) begin
      report_error($sformatf("unexpected byte 0x%02h on tx_o at %0d ns", got, $time));
    end else begin
      want = exp_q.pop_front();
      tnum = exp_test_q.pop_front();
      if (got !== want) begin
        report_error($sformatf(
          "MISMATCH at %0d ns: tx_o byte %0d of test %0d expected 0x%02h got 0x%02h",
          $time, byte_idx, tnum, want, got));
      end
      byte_idx++;
    end
  endtask

  task automatic finish_test(input int tnum);
    if (drop_seen != drop_expected) begin
      report_error($sformatf(
        "MISMATCH at %0d ns: drop_o pulses in test %0d expected %0d got %0d",
        $time, tnum, drop_expected, drop_seen));
    end
    tests_run++;
    if (test_errors == 0) begin
      $display("test %0d passed", tnum);
    end else begin
      tests_failed++;
      $display("test %0d failed with %0d errors", tnum, test_errors);
    end
    test_errors = 0;
    drop_seen = 0;
    byte_idx = 0;
  endtask

  task automatic print_counts();
    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
  endtask

  // tick counts cycles since the start bit began
  always @(posedge clk_i) begin
    if (reset_i) begin
      rx_busy = 1'b0;
      tick = 0;
    end else begin
      if (drop_i) begin
        drop_seen++;
      end
      if (!rx_busy) begin
        if (!tx_i) begin
          rx_busy = 1'b1;
          tick = 1;
        end
      end else begin
        tick++;
        if (tick == HalfBit) begin
          if (tx_i) begin
            report_error($sformatf("start bit on tx_o ended early at %0d ns", $time));
            rx_busy = 1'b0;
          end
        end else if (tick > HalfBit && (tick - HalfBit) % UartBitCycles == 0) begin
          bit_num = (tick - HalfBit) / UartBitCycles;
          if (bit_num <= 8) begin
            rx_byte[bit_num-1] = tx_i;
          end else begin
            if (!tx_i) begin
              report_error($sformatf("stop bit on tx_o was low at %0d ns", $time));
            end
            check_byte(rx_byte);
            rx_busy = 1'b0;
          end
        end
      end
    end
  end

endmodule

// File: test/trace_tb.sv
// runs from the project root; tests run in order and event cycles count from reset release
`timescale 1ns/10ps

module trace_tb;
  import trace_pkg::*;

  localparam int ClkPeriod = 40;
  localparam int ResetCycles = 3;
  localparam string StimFile = "test/trace_stim.txt";
  // event kinds in the stim file
  localparam int EvIdle = 0;
  localparam int EvIrq = 1;
  localparam int EvTail = 2;
  localparam int EvCsr = 3;

  logic                    clk_i;
  logic                    reset_i;
  logic                    irq_valid_i;
  logic [7:0]              irq_id_i;
  logic [7:0]              irq_prio_i;
  logic                    tail_chain_i;
  logic                    csr_enable_i;
  logic [CsrAddrWidth-1:0] csr_addr_i;
  logic [31:0]             rs1_data_i;
  logic                    tx_o;
  logic                    drop_o;

  int          cycle_cnt;
  int          cycle_limit;
  int          max_test;
  int          last_cycle;
  int          ev_test [$];
  int          ev_cycle [$];
  int          ev_type [$];
  logic [31:0] ev_f1 [$];
  logic [31:0] ev_f2 [$];
  int          xb_test [$];
  logic [7:0]  xb_val [$];
  int          dr_test [$];
  int          dr_count [$];

  trace_top uut (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .irq_valid_i (irq_valid_i),
    .irq_id_i    (irq_id_i),
    .irq_prio_i  (irq_prio_i),
    .tail_chain_i(tail_chain_i),
    .csr_enable_i(csr_enable_i),
    .csr_addr_i  (csr_addr_i),
    .rs1_data_i  (rs1_data_i),
    .tx_o        (tx_o),
    .drop_o      (drop_o)
  );

  trace_checker chk (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .tx_i   (tx_o),
    .drop_i (drop_o)
  );

  initial clk_i = 1'b0;
  always #(ClkPeriod / 2) clk_i = ~clk_i;

  // mirrors the DUT timer without the wrap
  always @(posedge clk_i) begin
    if (reset_i) begin
      cycle_cnt <= 0;
    end else begin
      cycle_cnt <= cycle_cnt + 1;
    end
  end

  always @(posedge clk_i) begin
    if (!reset_i && cycle_cnt >= cycle_limit) begin
      $display("timeout at cycle %0d, %0d bytes never arrived", cycle_cnt, chk.pending());
      chk.print_counts();
      $display("ERRORS FOUND");
      $finish;
    end
  end

  task automatic read_stim();
    int          fd;
    int          n;
    int          tnum;
    int          cyc;
    int          kind;
    logic [31:0] f1;
    logic [31:0] f2;
    logic [7:0]  b [FrameBytes];
    string       line;
    fd = $fopen(StimFile, "r");
    if (fd == 0) begin
      chk.report_error($sformatf("could not open stimulus file %s", StimFile));
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      tnum = 0;
      if (n > 1 && line[0] != "#") begin
        case (line[0])
          "E": begin
            n = $sscanf(line, "E %d %d %d %h %h", tnum, cyc, kind, f1, f2);
            if (n != 5) begin
              chk.report_error($sformatf("incomplete event line: %s", line));
            end
            ev_test.push_back(tnum);
            ev_cycle.push_back(cyc);
            ev_type.push_back(kind);
            ev_f1.push_back(f1);
            ev_f2.push_back(f2);
            if (cyc > last_cycle) begin
              last_cycle = cyc;
            end
          end
          "F": begin
            n = $sscanf(line, "F %d %h %h %h %h %h %h",
                        tnum, b[0], b[1], b[2], b[3], b[4], b[5]);
            if (n != FrameBytes + 1) begin
              chk.report_error($sformatf("incomplete frame line: %s", line));
            end
            for (int k = 0; k < FrameBytes; k++) begin
              xb_test.push_back(tnum);
              xb_val.push_back(b[k]);
            end
          end
          "D": begin
            n = $sscanf(line, "D %d %d", tnum, cyc);
            if (n != 2) begin
              chk.report_error($sformatf("incomplete drop line: %s", line));
            end
            dr_test.push_back(tnum);
            dr_count.push_back(cyc);
          end
          default: chk.report_error($sformatf("stimulus line not understood: %s", line));
        endcase
        if (tnum > max_test) begin
          max_test = tnum;
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic idle_inputs();
    irq_valid_i <= 1'b0;
    tail_chain_i <= 1'b0;
    csr_enable_i <= 1'b0;
  endtask

  // returns on the edge that opens cycle c with the strobes cleared
  task automatic wait_cycle(input int c);
    @(posedge clk_i);
    idle_inputs();
    while (cycle_cnt + 1 < c) begin
      @(posedge clk_i);
      idle_inputs();
    end
    if (cycle_cnt + 1 > c) begin
      chk.report_error($sformatf("event for cycle %0d driven late, at cycle %0d",
                                 c, cycle_cnt + 1));
    end
  endtask

  task automatic drive_event(input int k);
    case (ev_type[k])
      EvIrq, EvTail: begin
        irq_valid_i <= 1'b1;
        irq_id_i <= ev_f1[k][7:0];
        irq_prio_i <= ev_f2[k][7:0];
        tail_chain_i <= (ev_type[k] == EvTail);
      end
      EvCsr: begin
        csr_enable_i <= 1'b1;
        csr_addr_i <= ev_f1[k][CsrAddrWidth-1:0];
        rs1_data_i <= ev_f2[k];
      end
      EvIdle: ;
      default: begin
        chk.report_error($sformatf("unknown event type %0d in test %0d",
                                   ev_type[k], ev_test[k]));
      end
    endcase
  endtask

  task automatic load_expected(input int t);
    chk.expect_drops(0);
    for (int i = 0; i < xb_val.size(); i++) begin
      if (xb_test[i] == t) begin
        chk.expect_byte(t, xb_val[i]);
      end
    end
    for (int i = 0; i < dr_test.size(); i++) begin
      if (dr_test[i] == t) begin
        chk.expect_drops(dr_count[i]);
      end
    end
  endtask

  initial begin
    reset_i = 1'b1;
    irq_valid_i = 1'b0;
    irq_id_i = '0;
    irq_prio_i = '0;
    tail_chain_i = 1'b0;
    csr_enable_i = 1'b0;
    csr_addr_i = '0;
    rs1_data_i = '0;
    max_test = 0;
    last_cycle = 0;
    read_stim();
    cycle_limit = xb_val.size() * 10 * UartBitCycles + last_cycle + 200;
    repeat (ResetCycles) @(posedge clk_i);
    reset_i <= 1'b0;
    for (int t = 1; t <= max_test; t++) begin
      load_expected(t);
      for (int k = 0; k < ev_test.size(); k++) begin
        if (ev_test[k] == t) begin
          wait_cycle(ev_cycle[k]);
          drive_event(k);
        end
      end
      @(posedge clk_i);
      idle_inputs();
      // test is over once every expected byte came out
      @(negedge clk_i);
      while (chk.pending() != 0) begin
        @(negedge clk_i);
      end
      chk.finish_test(t);
    end
    chk.print_counts();
    if (chk.error_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: test/trace_stim.txt
# E test cycle type f1 f2 : type 0 idle 1 irq entry 2 tail chain 3 csr write, f1 id or addr, f2 prio or data (hex)
# F test b0..b5 : expected frame bytes in hex, D test n : expected drop pulses
E 1 60 0 0 0
D 1 0
E 2 70 1 2a 05
F 2 05 01 2a 05 46 00
D 2 0
E 3 340 1 00 11
E 3 341 2 07 00
E 3 512 3 7c0 dead0b00
F 3 02 01 03 11 54 00
F 3 03 02 07 02 55 00
F 3 03 03 0b 01 01 00
D 3 0
E 4 1100 3 3c0 cafe8107
E 4 1101 3 7c1 cafe8107
E 4 1102 3 7c0 cafe8107
F 4 05 03 81 07 4e 00
D 4 0
E 5 1400 1 10 80
E 5 1401 1 11 80
E 5 1402 1 12 80
E 5 1403 1 13 80
E 5 1404 1 14 80
E 5 1405 1 15 80
E 5 1406 1 16 80
F 5 05 01 10 80 78 00
F 5 05 01 11 80 79 00
F 5 05 01 12 80 7a 00
F 5 05 01 13 80 7b 00
F 5 05 01 14 80 7c 00
D 5 2

// File: trace_top.f
rtl/trace_pkg.sv
rtl/trace_encoder.sv
rtl/trace_fifo.sv
rtl/uart_tx.sv
rtl/trace_top.sv
test/trace_checker.sv
test/trace_tb.sv

// File: Bender.yml
package:
  name: trace_top

sources:
  - rtl/trace_pkg.sv
  - rtl/trace_encoder.sv
  - rtl/trace_fifo.sv
  - rtl/uart_tx.sv
  - rtl/trace_top.sv
  - target: test
    files:
      - test/trace_checker.sv
      - test/trace_tb.sv
